// File: verification/fetch_golden.txt
# stall redirect redirectAddr instr | idValid idPc idOp idRs idRt idImm16 idExc idExcCode held busy
# one line per clock after reset, all values hex, instr is the word at the current ifPc
# boot from bfc00000, all listed opcodes, 3-cycle stall
0 0 00000000 00000000 0 bfbffffc 00 00 00 0000 0 00 0 1
0 0 00000000 3c08bfc0 1 bfc00000 0f 00 08 bfc0 0 00 0 0
0 0 00000000 25090010 1 bfc00004 09 08 09 0010 0 00 0 0
0 0 00000000 8d2a0004 1 bfc00008 23 09 0a 0004 0 00 0 0
1 0 00000000 ad2b0008 1 bfc00008 23 09 0a 0004 0 00 1 0
1 0 00000000 ad2b0008 1 bfc00008 23 09 0a 0004 0 00 1 0
1 0 00000000 ad2b0008 1 bfc00008 23 09 0a 0004 0 00 1 0
0 0 00000000 ad2b0008 1 bfc0000c 2b 09 0b 0008 0 00 0 0
0 0 00000000 114bfffe 1 bfc00010 04 0a 0b fffe 0 00 0 0
0 0 00000000 14220003 1 bfc00014 05 01 02 0003 0 00 0 0
0 0 00000000 00221821 1 bfc00018 00 01 02 1821 0 00 0 0
0 0 00000000 04810005 1 bfc0001c 01 04 01 0005 0 00 0 0
0 0 00000000 0bf00010 1 bfc00020 02 1f 10 0010 0 00 0 0
0 0 00000000 0c000100 1 bfc00024 03 00 00 0100 0 00 0 0
# redirect to 80001000, then a redirect issued during a stall
0 1 80001000 00000000 0 00000000 00 00 00 0000 0 00 0 1
0 0 00000000 00000000 0 bfbffffc 00 00 00 0000 0 00 0 1
0 0 00000000 24020007 1 80001000 09 00 02 0007 0 00 0 0
0 0 00000000 3c051234 1 80001004 0f 00 05 1234 0 00 0 0
1 0 00000000 8ca60000 1 80001004 0f 00 05 1234 0 00 1 0
1 1 80002000 8ca60000 0 00000000 00 00 00 0000 0 00 0 1
1 0 00000000 00000000 0 00000000 00 00 00 0000 0 00 0 1
0 0 00000000 00000000 0 bfbffffc 00 00 00 0000 0 00 0 1
0 0 00000000 aca60004 1 80002000 2b 05 06 0004 0 00 0 0
0 0 00000000 fc640abc 1 80002004 3f 03 04 0abc 1 0a 0 0
0 0 00000000 10000002 1 80002008 04 00 00 0002 0 00 0 0
# misaligned target, address error wins over a reserved opcode
0 1 80003002 00000000 0 00000000 00 00 00 0000 0 00 0 1
0 0 00000000 00000000 0 bfbffffc 00 00 00 0000 0 00 0 1
0 0 00000000 fce81111 1 80003002 3f 07 08 1111 1 04 0 0
0 0 00000000 00000000 1 80003006 00 00 00 0000 1 04 0 0
# back to an aligned target, single stall, reserved cop0 opcode
0 1 80004000 00000000 0 00000000 00 00 00 0000 0 00 0 1
0 0 00000000 00000000 0 bfbffffc 00 00 00 0000 0 00 0 1
0 0 00000000 8c220008 1 80004000 23 01 02 0008 0 00 0 0
1 0 00000000 24430001 1 80004000 23 01 02 0008 0 00 1 0
0 0 00000000 24430001 1 80004004 09 02 03 0001 0 00 0 0
0 0 00000000 1443fffc 1 80004008 05 02 03 fffc 0 00 0 0
0 0 00000000 40856000 1 8000400c 10 04 05 6000 1 0a 0 0
0 0 00000000 08000400 1 80004010 02 00 00 0400 0 00 0 0
0 0 00000000 00000000 1 80004014 00 00 00 0000 0 00 0 0

// File: files.f
+incdir+include
logic/fetchPkg.sv
logic/pcSequencer.sv
logic/pfIfStage.sv
logic/ifIdStage.sv
logic/pipeCtrl.sv
logic/fetchFrontEnd.sv
verification/fetchFrontEnd_assertions.sv
verification/fetchFrontEnd_tb.sv

// File: Makefile
# Verilator flow for the fetch front end; run from the project root.

VERILATOR ?= verilator
TOP ?= fetchFrontEnd_tb
FILELIST ?= files.f
OBJDIR ?= obj_dir
VFLAGS ?= --timing --assert
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# a $fatal in the testbench gives a nonzero exit status
run: build
	./$(BIN)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// File: verification/fetchFrontEnd_tb.sv
`timescale 1ns/100ps

module fetchFrontEnd_tb;

	localparam string goldenPath = "verification/fetch_golden.txt";

	// columns of one golden line.
	localparam int colStall = 0;
	localparam int colRedirect = 1;
	localparam int colAddr = 2;
	localparam int colInstr = 3;
	localparam int colValid = 4;
	localparam int colPc = 5;
	localparam int colOp = 6;
	localparam int colRs = 7;
	localparam int colRt = 8;
	localparam int colImm = 9;
	localparam int colExc = 10;
	localparam int colCode = 11;
	localparam int colHeld = 12;
	localparam int colBusy = 13;
	localparam int colCount = 14;

	logic clk;
	logic rst;
	logic stall;
	logic redirect;
	logic [fetchPkg::addrWidth-1:0] redirectAddr;
	logic [fetchPkg::instrWidth-1:0] instr;
	logic [fetchPkg::addrWidth-1:0] ifPc;
	logic idValid;
	logic [fetchPkg::addrWidth-1:0] idPc;
	fetchPkg::opcodeE idOp;
	logic [fetchPkg::regIdxWidth-1:0] idRs;
	logic [fetchPkg::regIdxWidth-1:0] idRt;
	logic [fetchPkg::regIdxWidth-1:0] idRd;
	logic [fetchPkg::regIdxWidth-1:0] idShamt;
	logic [fetchPkg::functWidth-1:0] idFunct;
	logic [fetchPkg::imm16Width-1:0] idImm16;
	logic idExc;
	fetchPkg::excCodeE idExcCode;
	logic held;
	logic busy;

	logic [31:0] goldenWords[$]; // all lines, flattened.
	int lineCount;
	int cycleLimit = 0;
	int cycleCount = 0;
	int idx;

	fetchFrontEnd uut (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.redirectAddr(redirectAddr),
		.instr(instr),
		.ifPc(ifPc),
		.idValid(idValid),
		.idPc(idPc),
		.idOp(idOp),
		.idRs(idRs),
		.idRt(idRt),
		.idRd(idRd),
		.idShamt(idShamt),
		.idFunct(idFunct),
		.idImm16(idImm16),
		.idExc(idExc),
		.idExcCode(idExcCode),
		.held(held),
		.busy(busy)
	);

	always #2 clk = ~clk; // 4 ns period.

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Simulation failed");
			$fatal(1, "timeout, the run did not finish within %0d cycles", cycleLimit);
		end
	end

	function automatic bit isSkippable(input string text);
		byte first;
		if (text.len() == 0) begin
			return 1'b1;
		end
		first = text.getc(0);
		return (first == "#") || (first == "\n") || (first == "\r");
	endfunction

	function automatic logic [31:0] goldenAt(input int lineIdx, input int col);
		return goldenWords[lineIdx * colCount + col];
	endfunction

	task automatic loadGolden();
		int fd;
		int status;
		int got;
		int c;
		string text;
		logic [31:0] v [colCount];
		fd = $fopen(goldenPath, "r");
		if (fd == 0) begin
			$display("Simulation failed");
			$fatal(1, "cannot open the golden file %s", goldenPath);
		end
		while (!$feof(fd)) begin
			status = $fgets(text, fd);
			if (status != 0 && !isSkippable(text)) begin
				got = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6],
					v[7], v[8], v[9], v[10], v[11], v[12], v[13]);
				if (got != colCount) begin
					$display("Simulation failed");
					$fatal(1, "golden line has %0d values instead of %0d", got, colCount);
				end
				for (c = 0; c < colCount; c++) begin
					goldenWords.push_back(v[c]);
				end
			end
		end
		$fclose(fd);
		lineCount = goldenWords.size() / colCount;
		if (lineCount == 0) begin
			$display("Simulation failed");
			$fatal(1, "the golden file holds no stimulus lines");
		end
	endtask

	task automatic checkValue(input string name, input int lineIdx,
			input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s line %0d expected %h got %h", name, lineIdx, expected, actual);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// outputs after the edge that closed this line's cycle.
	task automatic checkLine(input int lineIdx);
		logic [31:0] imm;
		imm = goldenAt(lineIdx, colImm);
		checkValue("idValid", lineIdx, goldenAt(lineIdx, colValid), 32'(idValid));
		checkValue("idPc", lineIdx, goldenAt(lineIdx, colPc), 32'(idPc));
		checkValue("idOp", lineIdx, goldenAt(lineIdx, colOp), 32'(idOp));
		checkValue("idRs", lineIdx, goldenAt(lineIdx, colRs), 32'(idRs));
		checkValue("idRt", lineIdx, goldenAt(lineIdx, colRt), 32'(idRt));
		checkValue("idImm16", lineIdx, imm, 32'(idImm16));
		checkValue("idRd", lineIdx, 32'(imm[15:11]), 32'(idRd)); // rd, shamt, funct share imm16.
		checkValue("idShamt", lineIdx, 32'(imm[10:6]), 32'(idShamt));
		checkValue("idFunct", lineIdx, 32'(imm[5:0]), 32'(idFunct));
		checkValue("idExc", lineIdx, goldenAt(lineIdx, colExc), 32'(idExc));
		checkValue("idExcCode", lineIdx, goldenAt(lineIdx, colCode), 32'(idExcCode));
		checkValue("held", lineIdx, goldenAt(lineIdx, colHeld), 32'(held));
		checkValue("busy", lineIdx, goldenAt(lineIdx, colBusy), 32'(busy));
		// an advancing next line moves this ifPc into ID.
		if (lineIdx + 1 < lineCount && goldenAt(lineIdx + 1, colStall) == 0
				&& goldenAt(lineIdx + 1, colRedirect) == 0) begin
			checkValue("ifPc", lineIdx, goldenAt(lineIdx + 1, colPc), 32'(ifPc));
		end
	endtask

	task automatic driveLine(input int lineIdx);
		stall = goldenAt(lineIdx, colStall) != 0;
		redirect = goldenAt(lineIdx, colRedirect) != 0;
		redirectAddr = goldenAt(lineIdx, colAddr);
		instr = goldenAt(lineIdx, colInstr); // word for the current ifPc.
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		stall = 1'b0;
		redirect = 1'b0;
		redirectAddr = '0;
		instr = '0;
		loadGolden();
		cycleLimit = 2 * lineCount + 20;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		driveLine(0);
		for (idx = 1; idx < lineCount; idx++) begin
			@(negedge clk);
			checkLine(idx - 1);
			driveLine(idx);
		end
		@(negedge clk);
		checkLine(lineCount - 1);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: verification/fetchFrontEnd_assertions.sv
`timescale 1ns/100ps

module fetchFrontEnd_assertions #(
	parameter bit ctrlSide = 1'b0
) (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic advance,
	input logic held,
	input logic busy,
	input logic idValid
);

	generate
		if (ctrlSide) begin : ctrlChecks
			// HOLD and the fill states exclude each other.
			heldNotBusy: assert property (
				@(posedge clk) disable iff (rst) !(held && busy)
			) else $error("held and busy high together");
		end else begin : idChecks
			// a flush never doubles as a write.
			flushBlocksAdvance: assert property (
				@(posedge clk) disable iff (rst) flush |-> !advance
			) else $error("flush and advance high in the same cycle");

			flushEmptiesId: assert property (
				@(posedge clk) disable iff (rst) flush |=> !idValid
			) else $error("ID stage still valid after a flush");
		end
	endgenerate

endmodule

// controller side, no ID stage here.
bind pipeCtrl fetchFrontEnd_assertions #(.ctrlSide(1'b1)) ctrlRules (
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.advance(advance),
	.held(held),
	.busy(busy),
	.idValid(1'b0)
);

bind ifIdStage fetchFrontEnd_assertions #(.ctrlSide(1'b0)) idRules (
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.advance(advance),
	.held(1'b0),
	.busy(1'b0),
	.idValid(idValid)
);

// File: logic/fetchFrontEnd.sv
`timescale 1ns/100ps
`include "fetchDefs.svh"

module fetchFrontEnd #(
	parameter logic [fetchPkg::addrWidth-1:0] resetVector = `bootVector
) (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic redirect,
	input logic [fetchPkg::addrWidth-1:0] redirectAddr,
	input logic [fetchPkg::instrWidth-1:0] instr,
	output logic [fetchPkg::addrWidth-1:0] ifPc,
	output logic idValid,
	output logic [fetchPkg::addrWidth-1:0] idPc,
	output fetchPkg::opcodeE idOp,
	output logic [fetchPkg::regIdxWidth-1:0] idRs,
	output logic [fetchPkg::regIdxWidth-1:0] idRt,
	output logic [fetchPkg::regIdxWidth-1:0] idRd,
	output logic [fetchPkg::regIdxWidth-1:0] idShamt,
	output logic [fetchPkg::functWidth-1:0] idFunct,
	output logic [fetchPkg::imm16Width-1:0] idImm16,
	output logic idExc,
	output fetchPkg::excCodeE idExcCode,
	output logic held,
	output logic busy
);

	logic advance;
	logic flush;
	logic [fetchPkg::addrWidth-1:0] fetchPc;
	logic ifValid;
	logic ifExc;
	fetchPkg::excCodeE ifExcCode;

	pipeCtrl ctrl (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.advance(advance),
		.flush(flush),
		.held(held),
		.busy(busy)
	);

	pcSequencer #(.resetVector(resetVector)) pcSeq (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.load(flush), // redirect target.
		.loadAddr(redirectAddr),
		.fetchPc(fetchPc)
	);

	pfIfStage #(.resetVector(resetVector)) pfIf (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.flush(flush),
		.fetchPc(fetchPc),
		.ifPc(ifPc),
		.ifValid(ifValid),
		.ifExc(ifExc),
		.ifExcCode(ifExcCode)
	);

	ifIdStage ifId (
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.flush(flush),
		.ifPc(ifPc),
		.ifValid(ifValid),
		.ifExc(ifExc),
		.ifExcCode(ifExcCode),
		.instr(instr),
		.idValid(idValid),
		.idPc(idPc),
		.idOp(idOp),
		.idRs(idRs),
		.idRt(idRt),
		.idRd(idRd),
		.idShamt(idShamt),
		.idFunct(idFunct),
		.idImm16(idImm16),
		.idExc(idExc),
		.idExcCode(idExcCode)
	);

endmodule

// File: logic/pipeCtrl.sv
`timescale 1ns/100ps

module pipeCtrl (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic redirect,
	output logic advance,
	output logic flush,
	output logic held,
	output logic busy
);

	fetchPkg::ctrlStateE state;
	fetchPkg::ctrlStateE nextState;

	// redirect flushes even while stalled.
	assign advance = !stall && !redirect;
	assign flush = redirect;

	// FILL0 and FILL1 count the two edges needed to refill both latches.
	always_comb begin
		nextState = state;
		if (redirect) begin
			nextState = fetchPkg::FILL0;
		end else begin
			case (state)
				fetchPkg::FILL0: begin
					if (advance) begin
						nextState = fetchPkg::FILL1;
					end
				end
				fetchPkg::FILL1: begin
					if (advance) begin
						nextState = fetchPkg::RUN;
					end
				end
				fetchPkg::RUN: begin
					if (stall) begin
						nextState = fetchPkg::HOLD;
					end
				end
				fetchPkg::HOLD: begin
					if (!stall) begin
						nextState = fetchPkg::RUN;
					end
				end
				default: nextState = fetchPkg::FILL0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetchPkg::FILL0; // pipe starts empty.
		end else begin
			state <= nextState;
		end
	end

	assign held = (state == fetchPkg::HOLD);
	assign busy = (state == fetchPkg::FILL0) || (state == fetchPkg::FILL1);

endmodule

// File: logic/ifIdStage.sv
`timescale 1ns/100ps

module ifIdStage (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic flush,
	input logic [fetchPkg::addrWidth-1:0] ifPc,
	input logic ifValid,
	input logic ifExc,
	input fetchPkg::excCodeE ifExcCode,
	input logic [fetchPkg::instrWidth-1:0] instr,
	output logic idValid,
	output logic [fetchPkg::addrWidth-1:0] idPc,
	output fetchPkg::opcodeE idOp,
	output logic [fetchPkg::regIdxWidth-1:0] idRs,
	output logic [fetchPkg::regIdxWidth-1:0] idRt,
	output logic [fetchPkg::regIdxWidth-1:0] idRd,
	output logic [fetchPkg::regIdxWidth-1:0] idShamt,
	output logic [fetchPkg::functWidth-1:0] idFunct,
	output logic [fetchPkg::imm16Width-1:0] idImm16,
	output logic idExc,
	output fetchPkg::excCodeE idExcCode
);

	fetchPkg::opcodeE rawOp;
	logic opReserved;
	logic newExc;
	fetchPkg::excCodeE newExcCode;

	assign rawOp = fetchPkg::opcodeE'(instr[31:26]);

	always_comb begin
		case (rawOp)
			fetchPkg::SPECIAL, fetchPkg::REGIMM, fetchPkg::J, fetchPkg::JAL,
			fetchPkg::BEQ, fetchPkg::BNE, fetchPkg::ADDIU, fetchPkg::LUI,
			fetchPkg::LW, fetchPkg::SW: opReserved = 1'b0;
			default: opReserved = 1'b1;
		endcase
	end

	// a fetch fault is older than the decode fault and keeps its code.
	always_comb begin
		newExc = ifExc;
		newExcCode = ifExcCode;
		if (ifValid && !ifExc && opReserved) begin
			newExc = 1'b1;
			newExcCode = fetchPkg::EXC_RI;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			idValid <= 1'b0; // bubble.
			idPc <= '0;
			idOp <= fetchPkg::SPECIAL;
			idRs <= '0;
			idRt <= '0;
			idRd <= '0;
			idShamt <= '0;
			idFunct <= '0;
			idImm16 <= '0;
			idExc <= 1'b0;
			idExcCode <= fetchPkg::EXC_NONE;
		end else if (advance) begin
			idValid <= ifValid;
			idPc <= ifPc;
			idOp <= rawOp;
			idRs <= instr[25:21];
			idRt <= instr[20:16];
			idRd <= instr[15:11];
			idShamt <= instr[10:6];
			idFunct <= instr[5:0];
			idImm16 <= instr[15:0];
			idExc <= newExc;
			idExcCode <= newExcCode;
		end
	end

endmodule

// File: logic/pfIfStage.sv
`timescale 1ns/100ps

module pfIfStage #(
	parameter logic [fetchPkg::addrWidth-1:0] resetVector = '0
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic flush,
	input logic [fetchPkg::addrWidth-1:0] fetchPc,
	output logic [fetchPkg::addrWidth-1:0] ifPc,
	output logic ifValid,
	output logic ifExc,
	output fetchPkg::excCodeE ifExcCode
);

	localparam logic [fetchPkg::addrWidth-1:0] bubblePc = resetVector - 4;

	logic misaligned;

	assign misaligned = |fetchPc[1:0]; // word fetch only.

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ifPc <= bubblePc; // one word before boot.
			ifValid <= 1'b0;
			ifExc <= 1'b0;
			ifExcCode <= fetchPkg::EXC_NONE;
		end else if (advance) begin
			ifPc <= fetchPc;
			ifValid <= 1'b1;
			ifExc <= misaligned;
			ifExcCode <= misaligned ? fetchPkg::EXC_ADEL : fetchPkg::EXC_NONE;
		end
	end

endmodule

// File: logic/pcSequencer.sv
`timescale 1ns/100ps

module pcSequencer #(
	parameter logic [fetchPkg::addrWidth-1:0] resetVector = '0
) (
	input logic clk,
	input logic rst,
	input logic advance,
	input logic load,
	input logic [fetchPkg::addrWidth-1:0] loadAddr,
	output logic [fetchPkg::addrWidth-1:0] fetchPc
);

	localparam logic [fetchPkg::addrWidth-1:0] wordStep = 4;

	// load outranks advance, a redirect wins over a stall.
	always_ff @(posedge clk) begin
		if (rst) begin
			fetchPc <= resetVector; // boot address.
		end else if (load) begin
			fetchPc <= loadAddr;
		end else if (advance) begin
			fetchPc <= fetchPc + wordStep; // next word.
		end
	end

endmodule

// File: logic/fetchPkg.sv
package fetchPkg;

	parameter int addrWidth = 32;
	parameter int instrWidth = 32;
	parameter int regIdxWidth = 5;
	parameter int opWidth = 6;
	parameter int functWidth = 6;
	parameter int imm16Width = 16;

	// major opcodes decoded in ID; anything else is reserved.
	typedef enum logic [opWidth-1:0] {
		SPECIAL = 6'd0,
		REGIMM  = 6'd1,
		J       = 6'd2,
		JAL     = 6'd3,
		BEQ     = 6'd4,
		BNE     = 6'd5,
		ADDIU   = 6'd9,
		LUI     = 6'd15,
		LW      = 6'd35,
		SW      = 6'd43
	} opcodeE;

	// cp0 cause codes used by the front end.
	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_RI   = 5'd10
	} excCodeE;

	typedef enum logic [1:0] {
		FILL0,
		FILL1,
		RUN,
		HOLD
	} ctrlStateE;

endpackage

// File: include/fetchDefs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// boot ROM entry of the kseg1 segment.
`define bootVector 32'hbfc0_0000

`endif
